//--- source/pio_pkg.sv
package pio_pkg;

  // One program word
  typedef logic [15:0] instr_t;

  // Pins, scratch registers, OSR and FIFO entries
  typedef logic [31:0] word_t;

  // Program address or pin index
  typedef logic [4:0] addr_t;

  // Pin count for SET and OUT
  typedef logic [2:0] count_t;

  // Clock divisor
  typedef logic [15:0] div_t;

  typedef enum logic [2:0] {
    OP_JMP       = 3'd0,
    OP_WAIT      = 3'd1,
    OP_IN        = 3'd2,
    OP_OUT       = 3'd3,
    OP_PUSH_PULL = 3'd4,
    OP_MOV       = 3'd5,
    OP_IRQ       = 3'd6,
    OP_SET       = 3'd7
  } opcode_t;

  // MS_JUMP is the tick in which a taken jump lands in pc
  typedef enum logic {
    MS_EXEC = 1'b0,
    MS_JUMP = 1'b1
  } mstate_t;

  // Destinations in op1 of SET and OUT
  localparam logic [2:0] DEST_PINS    = 3'd0;
  localparam logic [2:0] DEST_X       = 3'd1;
  localparam logic [2:0] DEST_Y       = 3'd2;
  localparam logic [2:0] DEST_PINDIRS = 3'd4;

  // WAIT sources in op1[1:0]
  localparam logic [1:0] WAIT_GPIO = 2'd0;
  localparam logic [1:0] WAIT_IRQ  = 2'd2;

endpackage

//--- source/clock_divider.sv
module clock_divider
  import pio_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  div_t div,
  output logic penable
);

  div_t count;

  // 0 and 1 both mean full rate
  assign penable = (div <= 16'd1) || (count >= div - 16'd1);

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (penable) begin
      count <= '0;
    end else begin
      count <= count + 16'd1;
    end
  end

endmodule

//--- source/program_counter.sv
module program_counter
  import pio_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  penable,
  input  logic  jmp,
  input  addr_t target,
  input  logic  stalled,
  input  addr_t pstart,
  input  addr_t pend,
  output addr_t pc
);

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= pstart;
    end else if (penable) begin
      // A pending jump wins over a stall
      if (jmp) begin
        pc <= target;
      end else if (!stalled) begin
        if (pc == pend) begin
          pc <= pstart;
        end else begin
          pc <= pc + 5'd1;
        end
      end
    end
  end

endmodule

//--- source/scratch_register.sv
module scratch_register
  import pio_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  penable,
  input  word_t din,
  input  logic  set,
  input  logic  dec,
  output word_t dout
);

  always_ff @(posedge clk) begin
    if (reset) begin
      dout <= '0;
    end else if (penable) begin
      if (set) begin
        dout <= din;
      end else if (dec) begin
        // Wraps to all ones from zero
        dout <= dout - 32'd1;
      end
    end
  end

endmodule

//--- source/instr_decoder.sv
module instr_decoder
  import pio_pkg::*;
(
  input  instr_t     instr,
  output opcode_t    op,
  output logic [2:0] op1,
  output addr_t      op2,
  output logic [4:0] delay
);

  assign op  = opcode_t'(instr[15:13]);
  assign op1 = instr[7:5];
  assign op2 = instr[4:0];

  // No side-set, so the whole field is delay
  always_comb begin
    case (op)
      OP_IN,
      OP_MOV,
      OP_IRQ: begin
        // Unsupported opcodes run as a bare nop
        delay = 5'd0;
      end
      default: begin
        delay = instr[12:8];
      end
    endcase
  end

endmodule

//--- source/output_shift_register.sv
module output_shift_register
  import pio_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  penable,
  input  logic  load,
  input  word_t din,
  input  logic  shift,
  input  addr_t amount,
  input  logic  shift_right,
  output word_t shifted_out,
  output word_t osr
);

  // Bits already shifted out, 32 when empty
  logic [5:0] count;
  logic [5:0] bits;
  logic [5:0] avail;
  logic [5:0] take;
  word_t      mask;

  always_comb begin
    bits  = (amount == 5'd0) ? 6'd32 : {1'b0, amount};
    avail = 6'd32 - count;
    take  = (bits > avail) ? avail : bits;
    mask  = (take == 6'd32) ? '1 : ((32'd1 << take) - 32'd1);
    // Result is right-aligned either way
    if (shift_right) begin
      shifted_out = osr & mask;
    end else begin
      shifted_out = (osr >> (6'd32 - take)) & mask;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      osr   <= '0;
      count <= 6'd32;
    end else if (penable) begin
      if (load) begin
        osr   <= din;
        count <= 6'd0;
      end else if (shift) begin
        if (shift_right) begin
          osr <= osr >> bits;
        end else begin
          osr <= osr << bits;
        end
        count <= count + take;
      end
    end
  end

endmodule

//--- source/tx_fifo.sv
module tx_fifo
  import pio_pkg::*;
#(
  parameter int FIFO_DEPTH = 4
)
(
  input  logic  clk,
  input  logic  reset,
  input  logic  we,
  input  word_t wdata,
  input  logic  pop,
  output word_t rdata,
  output logic  empty,
  output logic  full
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  word_t            mem [FIFO_DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] count;
  logic             do_write;
  logic             do_pop;

  assign empty    = (count == '0);
  assign full     = (count == CNT_W'(FIFO_DEPTH));
  assign do_write = we && !full;
  assign do_pop   = pop && !empty;
  assign rdata    = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr] <= wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_write && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_write) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

//--- source/state_machine.sv
module state_machine
  import pio_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   en,
  input  div_t   div,
  input  instr_t instr,
  input  word_t  gpio_pins,
  input  word_t  irq_flags,
  input  word_t  fifo_data,
  input  logic   fifo_empty,
  input  addr_t  pstart,
  input  addr_t  pend,
  input  addr_t  pins_set_base,
  input  count_t pins_set_count,
  input  addr_t  pins_out_base,
  input  count_t pins_out_count,
  input  logic   shift_dir,
  output addr_t  pc,
  output logic   fifo_pop,
  output word_t  output_pins,
  output word_t  pin_directions
);

  logic       penable;
  logic       tick;
  mstate_t    state;
  logic       jmp;
  addr_t      jmp_target;
  logic [4:0] delay_cnt;
  logic       execute;
  logic       waiting;
  logic       stalled;
  logic       take_jmp;
  logic       setx;
  logic       sety;
  logic       decx;
  logic       decy;
  logic       load;
  logic       shift;
  count_t     set_count;
  opcode_t    op;
  logic [2:0] op1;
  addr_t      op2;
  logic [4:0] delay;
  word_t      new_val;
  word_t      x;
  word_t      y;
  word_t      osr;
  word_t      shifted_out;

  // Writes up to cnt bits of val from pin base, wrapping mod 32
  function automatic word_t write_field(word_t cur, word_t val, addr_t base, count_t cnt);
    word_t result;
    addr_t idx;
    result = cur;
    for (int i = 0; i < 7; i++) begin
      idx = base + addr_t'(i);
      if (i < int'(cnt)) begin
        result[idx] = val[i];
      end
    end
    return result;
  endfunction

  assign tick      = en && penable;
  assign jmp       = (state == MS_JUMP);
  assign execute   = tick && !jmp && (delay_cnt == 5'd0);
  assign stalled   = waiting || (delay_cnt != 5'd0);
  assign fifo_pop  = load;
  assign new_val   = {27'b0, op2};
  // SET carries at most five data bits
  assign set_count = (pins_set_count > 3'd5) ? 3'd5 : pins_set_count;

  always_comb begin
    take_jmp = 1'b0;
    waiting  = 1'b0;
    setx     = 1'b0;
    sety     = 1'b0;
    decx     = 1'b0;
    decy     = 1'b0;
    load     = 1'b0;
    shift    = 1'b0;
    if (execute) begin
      case (op)
        OP_JMP: begin
          case (op1)
            3'd0: take_jmp = 1'b1;
            3'd1: take_jmp = (x == '0);
            3'd2: begin
              take_jmp = (x != '0);
              decx     = 1'b1;
            end
            3'd3: take_jmp = (y == '0);
            3'd4: begin
              take_jmp = (y != '0);
              decy     = 1'b1;
            end
            3'd5: take_jmp = (x != y);
            // JMP PIN tests the first OUT pin
            3'd6: take_jmp = gpio_pins[pins_out_base];
            default: take_jmp = (osr != '0);
          endcase
        end
        OP_WAIT: begin
          case (op1[1:0])
            WAIT_GPIO: waiting = (gpio_pins[op2] != op1[2]);
            WAIT_IRQ:  waiting = (irq_flags[op2] != op1[2]);
            default:   waiting = 1'b0;
          endcase
        end
        OP_PUSH_PULL: begin
          // Only PULL, which blocks on an empty FIFO
          if (op1[2]) begin
            waiting = fifo_empty;
            load    = !fifo_empty;
          end
        end
        OP_OUT: shift = 1'b1;
        OP_SET: begin
          setx = (op1 == DEST_X);
          sety = (op1 == DEST_Y);
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state          <= MS_EXEC;
      delay_cnt      <= 5'd0;
      output_pins    <= '0;
      pin_directions <= '0;
    end else if (tick) begin
      if (delay_cnt != 5'd0) begin
        delay_cnt <= delay_cnt - 5'd1;
      end
      if (jmp) begin
        state <= MS_EXEC;
      end
      // Delay starts only once the instruction completes
      if (execute && !waiting) begin
        delay_cnt <= delay;
        if (take_jmp) begin
          state <= MS_JUMP;
        end
        if (op == OP_SET && op1 == DEST_PINS) begin
          output_pins <= write_field(output_pins, new_val, pins_set_base, set_count);
        end
        if (op == OP_SET && op1 == DEST_PINDIRS) begin
          pin_directions <= write_field(pin_directions, new_val, pins_set_base, set_count);
        end
        if (op == OP_OUT && op1 == DEST_PINS) begin
          output_pins <= write_field(output_pins, shifted_out, pins_out_base, pins_out_count);
        end
      end
    end
  end

  // Target captured with the jump, the decoder has moved on by then
  always_ff @(posedge clk) begin
    if (execute && take_jmp) begin
      jmp_target <= op2;
    end
  end

  clock_divider divider_inst (
    .clk     (clk),
    .reset   (reset),
    .div     (div),
    .penable (penable)
  );

  program_counter pc_inst (
    .clk     (clk),
    .reset   (reset),
    .penable (tick),
    .jmp     (jmp),
    .target  (jmp_target),
    .stalled (stalled),
    .pstart  (pstart),
    .pend    (pend),
    .pc      (pc)
  );

  scratch_register scratch_x (
    .clk     (clk),
    .reset   (reset),
    .penable (tick),
    .din     (new_val),
    .set     (setx),
    .dec     (decx),
    .dout    (x)
  );

  scratch_register scratch_y (
    .clk     (clk),
    .reset   (reset),
    .penable (tick),
    .din     (new_val),
    .set     (sety),
    .dec     (decy),
    .dout    (y)
  );

  instr_decoder decoder_inst (
    .instr (instr),
    .op    (op),
    .op1   (op1),
    .op2   (op2),
    .delay (delay)
  );

  output_shift_register osr_inst (
    .clk         (clk),
    .reset       (reset),
    .penable     (tick),
    .load        (load),
    .din         (fifo_data),
    .shift       (shift),
    .amount      (op2),
    .shift_right (shift_dir),
    .shifted_out (shifted_out),
    .osr         (osr)
  );

endmodule

//--- source/pio_block.sv
module pio_block
  import pio_pkg::*;
#(
  parameter int FIFO_DEPTH = 4
)
(
  input  logic   clk,
  input  logic   reset,
  input  logic   en,
  input  div_t   div,
  input  logic   prog_we,
  input  addr_t  prog_addr,
  input  instr_t prog_data,
  input  logic   tx_we,
  input  word_t  tx_data,
  output logic   tx_full,
  input  word_t  gpio_pins,
  input  word_t  irq_flags,
  input  addr_t  pstart,
  input  addr_t  pend,
  input  addr_t  pins_set_base,
  input  count_t pins_set_count,
  input  addr_t  pins_out_base,
  input  count_t pins_out_count,
  input  logic   shift_dir,
  output addr_t  pc,
  output word_t  output_pins,
  output word_t  pin_directions
);

  // Program memory, written by the host and read asynchronously at pc
  instr_t prog_mem [32];
  instr_t instr;
  word_t  fifo_data;
  logic   fifo_empty;
  logic   fifo_pop;

  always_ff @(posedge clk) begin
    if (prog_we) begin
      prog_mem[prog_addr] <= prog_data;
    end
  end

  assign instr = prog_mem[pc];

  tx_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) fifo_inst (
    .clk   (clk),
    .reset (reset),
    .we    (tx_we),
    .wdata (tx_data),
    .pop   (fifo_pop),
    .rdata (fifo_data),
    .empty (fifo_empty),
    .full  (tx_full)
  );

  state_machine machine_inst (
    .clk            (clk),
    .reset          (reset),
    .en             (en),
    .div            (div),
    .instr          (instr),
    .gpio_pins      (gpio_pins),
    .irq_flags      (irq_flags),
    .fifo_data      (fifo_data),
    .fifo_empty     (fifo_empty),
    .pstart         (pstart),
    .pend           (pend),
    .pins_set_base  (pins_set_base),
    .pins_set_count (pins_set_count),
    .pins_out_base  (pins_out_base),
    .pins_out_count (pins_out_count),
    .shift_dir      (shift_dir),
    .pc             (pc),
    .fifo_pop       (fifo_pop),
    .output_pins    (output_pins),
    .pin_directions (pin_directions)
  );

endmodule

//--- verif/pio_props.sv
module pio_props
  import pio_pkg::*;
(
  input logic       clk,
  input logic       reset,
  input addr_t      pc,
  input addr_t      pstart,
  input addr_t      pend,
  input logic       fifo_pop,
  input logic       fifo_empty,
  input logic [4:0] delay_cnt,
  input logic       jmp
);

  pop_not_empty: assert property (@(posedge clk) disable iff (reset)
    !(fifo_pop && fifo_empty))
    else $error("fifo_pop high while the FIFO is empty");

  pop_single_cycle: assert property (@(posedge clk) disable iff (reset)
    fifo_pop |=> !fifo_pop)
    else $error("fifo_pop held for more than one cycle");

  pc_in_range: assert property (@(posedge clk) disable iff (reset)
    (pc >= pstart) && (pc <= pend))
    else $error("pc outside pstart..pend");

  // A landing jump may move pc during a delay
  pc_held_in_delay: assert property (@(posedge clk) disable iff (reset)
    (delay_cnt != 5'd0 && !jmp) |=> $stable(pc))
    else $error("pc moved while the delay counter was running");

endmodule

bind state_machine pio_props props_inst (
  .clk        (clk),
  .reset      (reset),
  .pc         (pc),
  .pstart     (pstart),
  .pend       (pend),
  .fifo_pop   (fifo_pop),
  .fifo_empty (fifo_empty),
  .delay_cnt  (delay_cnt),
  .jmp        (jmp)
);

//--- verif/pio_tb.sv
module pio_tb
  import pio_pkg::*;
();

  localparam int TIMEOUT    = 2000;
  localparam int FIFO_DEPTH = 4;

  logic   clk;
  logic   reset;
  logic   en;
  div_t   div;
  logic   prog_we;
  addr_t  prog_addr;
  instr_t prog_data;
  logic   tx_we;
  word_t  tx_data;
  logic   tx_full;
  word_t  gpio_pins;
  word_t  irq_flags;
  addr_t  pstart;
  addr_t  pend;
  addr_t  pins_set_base;
  count_t pins_set_count;
  addr_t  pins_out_base;
  count_t pins_out_count;
  logic   shift_dir;
  addr_t  pc;
  word_t  output_pins;
  word_t  pin_directions;

  // Current test record
  string  tname;
  int     t_div;
  int     t_pstart;
  int     t_pend;
  int     t_sbase;
  int     t_scount;
  int     t_obase;
  int     t_ocount;
  int     t_sdir;
  int     t_halt;
  int     t_min;
  int     prog_addrs[$];
  instr_t prog_words[$];
  word_t  fifo_words[$];
  word_t  late_words[$];
  word_t  gpio_value;
  bit     has_gpio;
  word_t  exp_pins;
  word_t  exp_dirs;

  int          checks;
  int          value_errors;
  int          other_errors;
  int          tests_run;
  int unsigned seed = 87;

  pio_block #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) uut (
    .clk            (clk),
    .reset          (reset),
    .en             (en),
    .div            (div),
    .prog_we        (prog_we),
    .prog_addr      (prog_addr),
    .prog_data      (prog_data),
    .tx_we          (tx_we),
    .tx_data        (tx_data),
    .tx_full        (tx_full),
    .gpio_pins      (gpio_pins),
    .irq_flags      (irq_flags),
    .pstart         (pstart),
    .pend           (pend),
    .pins_set_base  (pins_set_base),
    .pins_set_count (pins_set_count),
    .pins_out_base  (pins_out_base),
    .pins_out_count (pins_out_count),
    .shift_dir      (shift_dir),
    .pc             (pc),
    .output_pins    (output_pins),
    .pin_directions (pin_directions)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  function automatic int unsigned next_random();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed >> 16;
  endfunction

  // Inputs change a little after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic compare_value(string name, word_t expected, word_t actual);
    checks++;
    if (expected !== actual) begin
      value_errors++;
      $display("ERR %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic push_word(word_t w);
    tx_we   = 1'b1;
    tx_data = w;
    next_cycle();
    tx_we   = 1'b0;
  endtask

  // tx_full rises once the FIFO holds FIFO_DEPTH words
  task automatic check_fifo_fill();
    word_t expected_full;
    reset = 1'b1;
    repeat (2) next_cycle();
    reset = 1'b0;
    for (int i = 1; i <= FIFO_DEPTH + 1; i++) begin
      push_word(word_t'(i));
      expected_full = (i >= FIFO_DEPTH) ? 32'd1 : 32'd0;
      compare_value($sformatf("fifo_fill word %0d tx_full", i), expected_full,
                    {31'b0, tx_full});
    end
  endtask

  task automatic run_test();
    int          cycles;
    int unsigned hold;
    bit          early;
    next_cycle();
    div            = div_t'(t_div);
    pstart         = addr_t'(t_pstart);
    pend           = addr_t'(t_pend);
    pins_set_base  = addr_t'(t_sbase);
    pins_set_count = count_t'(t_scount);
    pins_out_base  = addr_t'(t_obase);
    pins_out_count = count_t'(t_ocount);
    shift_dir      = t_sdir[0];
    en             = 1'b0;
    gpio_pins      = '0;
    reset          = 1'b1;
    repeat (2) next_cycle();
    reset = 1'b0;
    compare_value({tname, " reset pc"}, word_t'(t_pstart), {27'b0, pc});
    compare_value({tname, " reset pins"}, '0, output_pins);
    compare_value({tname, " reset dirs"}, '0, pin_directions);
    foreach (prog_addrs[i]) begin
      prog_we   = 1'b1;
      prog_addr = addr_t'(prog_addrs[i]);
      prog_data = prog_words[i];
      next_cycle();
    end
    prog_we = 1'b0;
    foreach (fifo_words[i]) begin
      push_word(fifo_words[i]);
    end
    en     = 1'b1;
    cycles = 0;
    early  = 1'b0;
    if (has_gpio || late_words.size() > 0) begin
      hold = 5 + next_random() % 20;
      // Machine should sit in WAIT or PULL until released
      while (cycles < hold) begin
        next_cycle();
        cycles++;
        if (pc == addr_t'(t_halt)) begin
          early = 1'b1;
        end
      end
      if (early) begin
        other_errors++;
        $display("%s: pc reached halt before the pin or FIFO release", tname);
      end
      if (has_gpio) begin
        gpio_pins = gpio_value;
      end
      foreach (late_words[i]) begin
        push_word(late_words[i]);
        cycles++;
      end
    end
    while (pc != addr_t'(t_halt) && cycles < TIMEOUT) begin
      next_cycle();
      cycles++;
    end
    if (pc != addr_t'(t_halt)) begin
      other_errors++;
      $display("%s: timed out waiting for pc to reach halt address %0d", tname, t_halt);
    end else begin
      compare_value({tname, " pins"}, exp_pins, output_pins);
      compare_value({tname, " dirs"}, exp_dirs, pin_directions);
      if (cycles < t_min * t_div) begin
        other_errors++;
        $display("%s: halt reached after %0d cycles, sooner than the delays allow",
                 tname, cycles);
      end
    end
    en = 1'b0;
    tests_run++;
  endtask

  initial begin
    int    fd;
    int    addr_tmp;
    word_t word_tmp;
    string line;
    string key;
    reset          = 1'b1;
    en             = 1'b0;
    div            = 16'd1;
    prog_we        = 1'b0;
    prog_addr      = '0;
    prog_data      = '0;
    tx_we          = 1'b0;
    tx_data        = '0;
    gpio_pins      = '0;
    irq_flags      = '0;
    pstart         = '0;
    pend           = 5'd31;
    pins_set_base  = '0;
    pins_set_count = '0;
    pins_out_base  = '0;
    pins_out_count = '0;
    shift_dir      = 1'b1;
    check_fifo_fill();
    fd = $fopen("verif/pio_golden.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("Could not open verif/pio_golden.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        key = "";
        void'($sscanf(line, "%s", key));
        case (key)
          "test": begin
            void'($sscanf(line, "%s %s %d %d %d %d %d %d %d %d %d %d", key, tname, t_div,
                          t_pstart, t_pend, t_sbase, t_scount, t_obase, t_ocount, t_sdir,
                          t_halt, t_min));
            prog_addrs.delete();
            prog_words.delete();
            fifo_words.delete();
            late_words.delete();
            has_gpio = 1'b0;
          end
          "prog": begin
            void'($sscanf(line, "%s %d %h", key, addr_tmp, word_tmp));
            prog_addrs.push_back(addr_tmp);
            prog_words.push_back(word_tmp[15:0]);
          end
          "fifo": begin
            void'($sscanf(line, "%s %h", key, word_tmp));
            fifo_words.push_back(word_tmp);
          end
          "late": begin
            void'($sscanf(line, "%s %h", key, word_tmp));
            late_words.push_back(word_tmp);
          end
          "gpio": begin
            void'($sscanf(line, "%s %h", key, gpio_value));
            has_gpio = 1'b1;
          end
          "expect": begin
            void'($sscanf(line, "%s %h %h", key, exp_pins, exp_dirs));
            run_test();
          end
          default: ;
        endcase
      end
      $fclose(fd);
    end
    if (tests_run == 0) begin
      other_errors++;
      $display("No test records were found in the golden file");
    end
    $display("Tests: %0d, checks: %0d, value errors: %0d, other errors: %0d",
             tests_run, checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- verif/pio_golden.txt
# test: name div pstart pend set_base set_count out_base out_count shift_dir halt min_ticks
# prog addr word, fifo word (before en), late word / gpio value (after a random hold), expect pins dirs
test set_wrap 1 0 31 30 4 0 1 1 2 0
prog 0 e01f
prog 1 e085
prog 2 0002
expect c0000003 40000001
test x_loop 1 0 31 0 1 0 1 1 5 0
prog 0 8080
prog 1 e023
prog 2 6001
prog 3 0042
prog 4 e081
prog 5 0005
fifo 0000000a
expect 00000001 00000001
test wait_gpio 2 8 10 8 5 0 1 1 10 0
prog 8 2083
prog 9 e01b
prog 10 000a
gpio 00000008
expect 00001b00 00000000
test pull_out 1 0 31 0 1 4 4 0 4 0
prog 0 8080
prog 1 6008
prog 2 8080
prog 3 6004
prog 4 0004
fifo 3c000000
late 90000000
expect 00000090 00000000
test delay_div 4 0 31 0 2 0 1 1 2 8
prog 0 e703
prog 1 e583
prog 2 0002
expect 00000003 00000003

//--- list.f
source/pio_pkg.sv
source/clock_divider.sv
source/program_counter.sv
source/scratch_register.sv
source/instr_decoder.sv
source/output_shift_register.sv
source/tx_fifo.sv
source/state_machine.sv
source/pio_block.sv
verif/pio_props.sv
verif/pio_tb.sv
